// ==== hdl/SchedulerPkg.sv ====
/*
 * Shared constants and types of the issue scheduler.
 * Queue and register file sizes, index widths, and the
 * vector types used for entry indices and per-entry masks.
 */

package SchedulerPkg;

    // Physical register file.
    localparam int PREG_NUM = 16;
    localparam int PREG_NUM_BIT_WIDTH = 4;

    // Issue queue geometry.
    localparam int ISSUE_QUEUE_ENTRY_NUM = 8;
    localparam int ISSUE_QUEUE_INDEX_BIT_WIDTH = 3;

    // Source operands per instruction.
    localparam int ISSUE_QUEUE_SRC_REG_NUM = 2;

    // Physical register number.
    typedef logic [PREG_NUM_BIT_WIDTH-1:0] PRegNumPath;

    // Queue entry index.
    typedef logic [ISSUE_QUEUE_INDEX_BIT_WIDTH-1:0] IssueQueueIndexPath;

    // One bit per queue entry.
    // Dependency rows, store vector, valid bits and wakeup vector.
    typedef logic [ISSUE_QUEUE_ENTRY_NUM-1:0] IssueQueueOneHotPath;

endpackage : SchedulerPkg

// ==== hdl/WakeupSelectIf.sv ====
/*
 * Signals shared by the allocator, the wakeup logic and the select logic.
 * One modport per block.
 */

`timescale 1ns/1ps

interface WakeupSelectIf (
    input logic clk,
    input logic reset,
    input logic stall
);
    // Dispatch into the queue.
    logic write;
    SchedulerPkg::IssueQueueIndexPath writePtr;

    // Valid entries that are not leaving this cycle.
    SchedulerPkg::IssueQueueOneHotPath notIssued;

    // Per-entry readiness.
    SchedulerPkg::IssueQueueOneHotPath opReady;

    // Entry being issued and its destination tag.
    logic wakeup;
    SchedulerPkg::IssueQueueOneHotPath wakeupVector;
    logic wakeupDstValid;
    SchedulerPkg::PRegNumPath wakeupDstRegNum;

    modport Allocator (
        input clk, reset, stall, wakeup, wakeupVector,
        output write, writePtr, notIssued
    );

    modport WakeupLogic (
        input clk, reset, stall, write, writePtr, notIssued,
        input wakeup, wakeupVector, wakeupDstValid, wakeupDstRegNum,
        output opReady
    );

    modport Select (
        input clk, reset, stall, opReady, write, writePtr,
        output wakeup, wakeupVector, wakeupDstValid, wakeupDstRegNum
    );

endinterface : WakeupSelectIf

// ==== hdl/ReadyBitTable.sv ====
/*
 * Ready bit and producer entry index per physical register.
 * Looks up the sources of a dispatched instruction.
 */

`timescale 1ns/1ps

module ReadyBitTable #(
    parameter int pregNum = SchedulerPkg::PREG_NUM
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic dispatch,
    input  logic dispatchedDstValid,
    input  SchedulerPkg::PRegNumPath dispatchedDstRegNum,
    input  logic dispatchedSrcValid [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input  SchedulerPkg::PRegNumPath dispatchedSrcRegNum [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    output logic dispatchedSrcReady [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    output SchedulerPkg::IssueQueueIndexPath dispatchedSrcPtr [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input  logic wakeupDstValid,
    input  SchedulerPkg::PRegNumPath wakeupDstRegNum,
    input  SchedulerPkg::IssueQueueIndexPath writePtr
);
    logic readyBit [pregNum];
    SchedulerPkg::IssueQueueIndexPath producerPtr [pregNum];

    // Source lookup, with a bypass from the register being woken this cycle.
    always_comb begin
        for (int i = 0; i < SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM; i++) begin
            dispatchedSrcReady[i] = !dispatchedSrcValid[i] ||
                readyBit[dispatchedSrcRegNum[i]] ||
                (wakeupDstValid && wakeupDstRegNum == dispatchedSrcRegNum[i]);
            dispatchedSrcPtr[i] = producerPtr[dispatchedSrcRegNum[i]];
        end
    end

    // A dispatched destination overrides a wakeup of the same register.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < pregNum; r++) begin
                readyBit[r] <= 1'b1;
            end
        end else if (!stall) begin
            if (wakeupDstValid) begin
                readyBit[wakeupDstRegNum] <= 1'b1;
            end
            if (dispatch && dispatchedDstValid) begin
                readyBit[dispatchedDstRegNum] <= 1'b0;
            end
        end
    end

    // Entry that will produce the register.
    always_ff @(posedge clk) begin
        if (!stall && dispatch && dispatchedDstValid) begin
            producerPtr[dispatchedDstRegNum] <= writePtr;
        end
    end

endmodule : ReadyBitTable

// ==== hdl/ProducerMatrix.sv ====
/*
 * Producer matrix with one dependency row per queue entry.
 * Rows are written on dispatch and cleared by column on wakeup.
 */

`timescale 1ns/1ps

module ProducerMatrix #(
    parameter int entryNum = SchedulerPkg::ISSUE_QUEUE_ENTRY_NUM
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic dispatch,
    input  SchedulerPkg::IssueQueueIndexPath dispatchPtr,
    input  logic dispatchedSrcReady [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input  SchedulerPkg::IssueQueueIndexPath dispatchedSrcPtr [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input  SchedulerPkg::IssueQueueOneHotPath dependStoreBitVector,
    input  logic wakeup,
    input  SchedulerPkg::IssueQueueOneHotPath wakeupDstVector,
    output SchedulerPkg::IssueQueueOneHotPath opReady
);
    SchedulerPkg::IssueQueueOneHotPath matrix [entryNum];
    SchedulerPkg::IssueQueueOneHotPath dispatchedRow;

    // Producers of sources still waiting, plus earlier stores if predicted.
    always_comb begin
        dispatchedRow = dependStoreBitVector;
        for (int j = 0; j < SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM; j++) begin
            if (!dispatchedSrcReady[j]) begin
                dispatchedRow[dispatchedSrcPtr[j]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < entryNum; i++) begin
                matrix[i] <= '0;
            end
        end else if (!stall) begin
            if (wakeup) begin
                for (int i = 0; i < entryNum; i++) begin
                    matrix[i] <= matrix[i] & ~wakeupDstVector;
                end
            end
            // The dispatched entry is free, so it never holds the wakeup column.
            if (dispatch) begin
                matrix[dispatchPtr] <= dispatchedRow;
            end
        end
    end

    // An entry is ready once no producer bit is left in its row.
    always_comb begin
        opReady = '0;
        for (int i = 0; i < entryNum; i++) begin
            opReady[i] = ~|matrix[i];
        end
    end

endmodule : ProducerMatrix

// ==== hdl/WakeupLogic.sv ====
/*
 * Wakeup logic of the matrix scheduler.
 * Ready bit table, producer matrix, store bit vector for
 * memory-dependence prediction, and per-entry readiness.
 */

`timescale 1ns/1ps

module WakeupLogic #(
    parameter int entryNum = SchedulerPkg::ISSUE_QUEUE_ENTRY_NUM,
    parameter int pregNum = SchedulerPkg::PREG_NUM
) (
    WakeupSelectIf.WakeupLogic port,
    input logic srcValid [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input SchedulerPkg::PRegNumPath srcRegNum [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input logic dstValid,
    input SchedulerPkg::PRegNumPath dstRegNum,
    input logic isStore,
    input logic isLoad,
    input logic memDepPred
);
    logic srcReady [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM];
    SchedulerPkg::IssueQueueIndexPath srcPtr [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM];

    SchedulerPkg::IssueQueueOneHotPath writeOneHot;
    SchedulerPkg::IssueQueueOneHotPath storeBitVector;
    SchedulerPkg::IssueQueueOneHotPath storeBitVectorReg;
    SchedulerPkg::IssueQueueOneHotPath dependStoreBitVector;
    SchedulerPkg::IssueQueueOneHotPath matrixReady;
    SchedulerPkg::IssueQueueOneHotPath entryValid;

    ReadyBitTable #(
        .pregNum(pregNum)
    ) readyBitTable_i (
        .clk(port.clk),
        .reset(port.reset),
        .stall(port.stall),
        .dispatch(port.write),
        .dispatchedDstValid(dstValid),
        .dispatchedDstRegNum(dstRegNum),
        .dispatchedSrcValid(srcValid),
        .dispatchedSrcRegNum(srcRegNum),
        .dispatchedSrcReady(srcReady),
        .dispatchedSrcPtr(srcPtr),
        .wakeupDstValid(port.wakeupDstValid),
        .wakeupDstRegNum(port.wakeupDstRegNum),
        .writePtr(port.writePtr)
    );

    ProducerMatrix #(
        .entryNum(entryNum)
    ) producerMatrix_i (
        .clk(port.clk),
        .reset(port.reset),
        .stall(port.stall),
        .dispatch(port.write),
        .dispatchPtr(port.writePtr),
        .dispatchedSrcReady(srcReady),
        .dispatchedSrcPtr(srcPtr),
        .dependStoreBitVector(dependStoreBitVector),
        .wakeup(port.wakeup),
        .wakeupDstVector(port.wakeupVector),
        .opReady(matrixReady)
    );

    always_comb begin
        writeOneHot = '0;
        if (port.write) begin
            writeOneHot[port.writePtr] = 1'b1;
        end

        // Stores still in the queue after this cycle's issue.
        storeBitVector = storeBitVectorReg & port.notIssued;

        // Predicted-dependent load waits for every store left in the queue.
        dependStoreBitVector = '0;
        if (port.write && isLoad && memDepPred) begin
            dependStoreBitVector = storeBitVector;
        end
        if (port.write && isStore) begin
            storeBitVector = storeBitVector | writeOneHot;
        end
    end

    // Store vector and a local copy of the entry valid bits.
    always_ff @(posedge port.clk) begin
        if (port.reset) begin
            storeBitVectorReg <= '0;
            entryValid <= '0;
        end else if (!port.stall) begin
            storeBitVectorReg <= storeBitVector;
            entryValid <= port.notIssued | writeOneHot;
        end
    end

    // Free entries never request issue.
    assign port.opReady = matrixReady & entryValid;

endmodule : WakeupLogic

// ==== hdl/EntryAllocator.sv ====
/*
 * Issue queue entry allocator.
 * Entry valid bits, lowest free entry as write pointer, full flag.
 */

`timescale 1ns/1ps

module EntryAllocator #(
    parameter int entryNum = SchedulerPkg::ISSUE_QUEUE_ENTRY_NUM
) (
    WakeupSelectIf.Allocator port,
    input  logic dispatchValid,
    output logic full
);
    SchedulerPkg::IssueQueueOneHotPath entryValid;
    SchedulerPkg::IssueQueueOneHotPath issueMask;

    always_comb begin
        full = &entryValid[entryNum-1:0];
        port.write = dispatchValid && !full && !port.stall;

        // Lowest free entry wins.
        port.writePtr = '0;
        for (int i = entryNum - 1; i >= 0; i--) begin
            if (!entryValid[i]) begin
                port.writePtr = SchedulerPkg::IssueQueueIndexPath'(i);
            end
        end

        issueMask = port.wakeup ? port.wakeupVector : '0;
        port.notIssued = entryValid & ~issueMask;
    end

    always_ff @(posedge port.clk) begin
        if (port.reset) begin
            entryValid <= '0;
        end else if (!port.stall) begin
            entryValid <= port.notIssued;
            if (port.write) begin
                entryValid[port.writePtr] <= 1'b1;
            end
        end
    end

endmodule : EntryAllocator

// ==== hdl/SelectLogic.sv ====
/*
 * Select logic.
 * Picks the lowest-index ready entry, drives the wakeup
 * vector and tag, and registers the issue outputs.
 */

`timescale 1ns/1ps

module SelectLogic #(
    parameter int entryNum = SchedulerPkg::ISSUE_QUEUE_ENTRY_NUM
) (
    WakeupSelectIf.Select port,
    input  logic dstValid,
    input  SchedulerPkg::PRegNumPath dstRegNum,
    output logic issueValid,
    output SchedulerPkg::IssueQueueIndexPath issueEntry,
    output logic issueDstValid,
    output SchedulerPkg::PRegNumPath issueDstRegNum
);
    // Destination of each queued instruction.
    logic entryDstValid [entryNum];
    SchedulerPkg::PRegNumPath entryDstRegNum [entryNum];

    logic selFound;
    SchedulerPkg::IssueQueueIndexPath selPtr;

    always_ff @(posedge port.clk) begin
        if (port.write) begin
            entryDstValid[port.writePtr] <= dstValid;
            entryDstRegNum[port.writePtr] <= dstRegNum;
        end
    end

    always_comb begin
        selFound = 1'b0;
        selPtr = '0;
        for (int i = entryNum - 1; i >= 0; i--) begin
            if (port.opReady[i]) begin
                selFound = 1'b1;
                selPtr = SchedulerPkg::IssueQueueIndexPath'(i);
            end
        end

        // Nothing leaves the queue while stalled.
        port.wakeup = selFound && !port.stall;
        port.wakeupVector = '0;
        if (port.wakeup) begin
            port.wakeupVector[selPtr] = 1'b1;
        end
        port.wakeupDstValid = port.wakeup && entryDstValid[selPtr];
        port.wakeupDstRegNum = entryDstRegNum[selPtr];
    end

    always_ff @(posedge port.clk) begin
        if (port.reset) begin
            issueValid <= 1'b0;
            issueEntry <= '0;
            issueDstValid <= 1'b0;
            issueDstRegNum <= '0;
        end else begin
            issueValid <= port.wakeup;
            if (port.wakeup) begin
                issueEntry <= selPtr;
                issueDstValid <= port.wakeupDstValid;
                issueDstRegNum <= port.wakeupDstRegNum;
            end
        end
    end

endmodule : SelectLogic

// ==== hdl/IssueScheduler.sv ====
/*
 * Top level of the issue scheduler.
 * Allocator, wakeup logic and select logic joined by WakeupSelectIf.
 */

`timescale 1ns/1ps

module IssueScheduler #(
    parameter int entryNum = SchedulerPkg::ISSUE_QUEUE_ENTRY_NUM,
    parameter int pregNum = SchedulerPkg::PREG_NUM
) (
    input  logic clk,
    input  logic reset,
    input  logic stall,
    input  logic dispatchValid,
    input  logic srcValid [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input  SchedulerPkg::PRegNumPath srcRegNum [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM],
    input  logic dstValid,
    input  SchedulerPkg::PRegNumPath dstRegNum,
    input  logic isStore,
    input  logic isLoad,
    input  logic memDepPred,
    output logic full,
    output logic issueValid,
    output SchedulerPkg::IssueQueueIndexPath issueEntry,
    output logic issueDstValid,
    output SchedulerPkg::PRegNumPath issueDstRegNum
);
    WakeupSelectIf wsIf (
        .clk(clk),
        .reset(reset),
        .stall(stall)
    );

    EntryAllocator #(
        .entryNum(entryNum)
    ) entryAllocator_i (
        .port(wsIf.Allocator),
        .dispatchValid(dispatchValid),
        .full(full)
    );

    WakeupLogic #(
        .entryNum(entryNum),
        .pregNum(pregNum)
    ) wakeupLogic_i (
        .port(wsIf.WakeupLogic),
        .srcValid(srcValid),
        .srcRegNum(srcRegNum),
        .dstValid(dstValid),
        .dstRegNum(dstRegNum),
        .isStore(isStore),
        .isLoad(isLoad),
        .memDepPred(memDepPred)
    );

    SelectLogic #(
        .entryNum(entryNum)
    ) selectLogic_i (
        .port(wsIf.Select),
        .dstValid(dstValid),
        .dstRegNum(dstRegNum),
        .issueValid(issueValid),
        .issueEntry(issueEntry),
        .issueDstValid(issueDstValid),
        .issueDstRegNum(issueDstRegNum)
    );

endmodule : IssueScheduler

// ==== dv/IssueSchedulerTb.sv ====
/*
 * Testbench of the issue scheduler.
 * Replays per-cycle stimulus from the golden file, checks full and the
 * issue outputs after each rising edge, and reports per test.
 */

`timescale 1ns/1ps

module IssueSchedulerTb;

    localparam int fieldNum = 17;
    localparam int maxLines = 64;

    logic clk;
    logic reset;
    logic stall;
    logic dispatchValid;
    logic srcValid [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM];
    SchedulerPkg::PRegNumPath srcRegNum [SchedulerPkg::ISSUE_QUEUE_SRC_REG_NUM];
    logic dstValid;
    SchedulerPkg::PRegNumPath dstRegNum;
    logic isStore;
    logic isLoad;
    logic memDepPred;
    logic full;
    logic issueValid;
    SchedulerPkg::IssueQueueIndexPath issueEntry;
    logic issueDstValid;
    SchedulerPkg::PRegNumPath issueDstRegNum;

    // One hex digit per field, fieldNum fields per cycle.
    logic [3:0] golden [fieldNum*maxLines];
    int lineCount;
    int cycleCount;
    int cycleLimit;
    bit limitSet;
    int errorCount;
    int testErrors;
    int testsRun;
    int testsFailed;

    IssueScheduler #(
        .entryNum(SchedulerPkg::ISSUE_QUEUE_ENTRY_NUM),
        .pregNum(SchedulerPkg::PREG_NUM)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .dispatchValid(dispatchValid),
        .srcValid(srcValid),
        .srcRegNum(srcRegNum),
        .dstValid(dstValid),
        .dstRegNum(dstRegNum),
        .isStore(isStore),
        .isLoad(isLoad),
        .memDepPred(memDepPred),
        .full(full),
        .issueValid(issueValid),
        .issueEntry(issueEntry),
        .issueDstValid(issueDstValid),
        .issueDstRegNum(issueDstRegNum)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Ends the run if the replay takes longer than the golden file allows.
    initial begin
        cycleCount = 0;
        wait (limitSet);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    task automatic driveLine(input int base);
        dispatchValid = golden[base+1][0];
        stall = golden[base+2][0];
        srcValid[0] = golden[base+3][0];
        srcRegNum[0] = golden[base+4];
        srcValid[1] = golden[base+5][0];
        srcRegNum[1] = golden[base+6];
        dstValid = golden[base+7][0];
        dstRegNum = golden[base+8];
        isStore = golden[base+9][0];
        isLoad = golden[base+10][0];
        memDepPred = golden[base+11][0];
    endtask

    task automatic reportMismatch(input string name, input logic [3:0] expected,
                                  input logic [3:0] actual);
        $display("ERR at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
        testErrors++;
    endtask

    // Entry and destination only mean something when an issue is expected.
    task automatic checkLine(input int base);
        if (full !== golden[base+12][0]) begin
            reportMismatch("full", golden[base+12], 4'(full));
        end
        if (issueValid !== golden[base+13][0]) begin
            reportMismatch("issueValid", golden[base+13], 4'(issueValid));
        end
        if (golden[base+13][0] && issueEntry !== golden[base+14][2:0]) begin
            reportMismatch("issueEntry", golden[base+14], 4'(issueEntry));
        end
        if (golden[base+13][0] && issueDstValid !== golden[base+15][0]) begin
            reportMismatch("issueDstValid", golden[base+15], 4'(issueDstValid));
        end
        if (golden[base+15][0] && issueDstRegNum !== golden[base+16]) begin
            reportMismatch("issueDstRegNum", golden[base+16], issueDstRegNum);
        end
    endtask

    task automatic finishTest(input int testNum);
        testsRun++;
        if (testErrors == 0) begin
            $display("Test %0d passed", testNum);
        end else begin
            $display("Test %0d failed with %0d errors", testNum, testErrors);
            testsFailed++;
        end
        errorCount += testErrors;
        testErrors = 0;
    endtask

    initial begin
        int currentTest;
        int base;
        reset = 1'b1;
        stall = 1'b0;
        dispatchValid = 1'b0;
        srcValid[0] = 1'b0;
        srcValid[1] = 1'b0;
        srcRegNum[0] = '0;
        srcRegNum[1] = '0;
        dstValid = 1'b0;
        dstRegNum = '0;
        isStore = 1'b0;
        isLoad = 1'b0;
        memDepPred = 1'b0;
        errorCount = 0;
        testErrors = 0;
        testsRun = 0;
        testsFailed = 0;
        for (int i = 0; i < fieldNum*maxLines; i++) begin
            golden[i] = 4'h0;
        end
        $readmemh("dv/schedulerGolden.txt", golden);

        // Test number zero marks the end of the stimulus.
        lineCount = 0;
        while (lineCount < maxLines && golden[lineCount*fieldNum] != 4'h0) begin
            lineCount++;
        end
        cycleLimit = lineCount + 20;
        limitSet = 1'b1;
        if (lineCount == 0) begin
            $display("The golden file is missing or holds no stimulus lines");
            errorCount++;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        currentTest = int'(golden[0]);
        for (int n = 0; n < lineCount; n++) begin
            base = n * fieldNum;
            if (int'(golden[base]) != currentTest) begin
                finishTest(currentTest);
                currentTest = int'(golden[base]);
            end
            driveLine(base);
            @(posedge clk);
            @(negedge clk);
            checkLine(base);
        end
        if (lineCount > 0) begin
            finishTest(currentTest);
        end

        $display("Tests run: %0d, failed: %0d, errors: %0d", testsRun, testsFailed, errorCount);
        if (errorCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule : IssueSchedulerTb

// ==== dv/schedulerGolden.txt ====
// Columns: test dispatchValid stall src0Valid src0Reg src1Valid src1Reg dstValid dstReg
// isStore isLoad memDepPred, then expected full issueValid issueEntry issueDstValid issueDstReg.
// Test 1 independent instructions, one issue per cycle.
1  1 0  0 0 0 0  1 1  0 0 0  0 0 0 0 0
1  1 0  0 0 0 0  1 2  0 0 0  0 1 0 1 1
1  1 0  0 0 0 0  0 0  0 0 0  0 1 1 1 2
1  1 0  1 1 1 2  1 3  0 0 0  0 1 0 0 0
1  0 0  0 0 0 0  0 0  0 0 0  0 1 1 1 3
// Test 2 dependent chain issues back to back.
2  1 0  0 0 0 0  1 4  0 0 0  0 0 0 0 0
2  1 0  1 4 0 0  1 5  0 0 0  0 1 0 1 4
2  1 0  1 5 1 4  1 6  0 0 0  0 1 1 1 5
2  1 0  0 0 1 6  1 7  0 0 0  0 1 0 1 6
2  0 0  0 0 0 0  0 0  0 0 0  0 1 1 1 7
// Test 3 two consumers of one producer.
3  1 0  0 0 0 0  1 8  0 0 0  0 0 0 0 0
3  1 0  1 8 0 0  1 9  0 0 0  0 1 0 1 8
3  1 0  0 0 1 8  1 a  0 0 0  0 1 1 1 9
3  0 0  0 0 0 0  0 0  0 0 0  0 1 0 1 a
// Test 4 stores, predicted and plain loads.
4  1 0  1 1 1 2  0 0  1 0 0  0 0 0 0 0
4  1 0  1 3 0 0  1 b  0 1 1  0 1 0 0 0
4  1 0  1 b 0 0  0 0  1 0 0  0 1 1 1 b
4  1 0  1 1 0 0  1 c  0 1 0  0 1 0 0 0
4  1 0  1 3 0 0  1 d  0 1 1  0 1 1 1 c
4  0 0  0 0 0 0  0 0  0 0 0  0 1 0 1 d
// Test 5 burst of nine dispatches, entries recycle.
5  1 0  0 0 0 0  1 e  0 0 0  0 0 0 0 0
5  1 0  0 0 0 0  1 f  0 0 0  0 1 0 1 e
5  1 0  0 0 0 0  1 1  0 0 0  0 1 1 1 f
5  1 0  1 1 0 0  1 2  0 0 0  0 1 0 1 1
5  1 0  0 0 0 0  1 3  0 0 0  0 1 1 1 2
5  1 0  0 0 0 0  1 4  0 0 0  0 1 0 1 3
5  1 0  0 0 0 0  1 5  0 0 0  0 1 1 1 4
5  1 0  0 0 0 0  1 6  0 0 0  0 1 0 1 5
5  1 0  0 0 0 0  1 7  0 0 0  0 1 1 1 6
5  0 0  0 0 0 0  0 0  0 0 0  0 1 0 1 7
// Test 6 stall holds the queue and the dispatch.
6  1 0  0 0 0 0  1 8  0 0 0  0 0 0 0 0
6  1 1  0 0 0 0  1 9  0 0 0  0 0 0 0 0
6  1 1  0 0 0 0  1 9  0 0 0  0 0 0 0 0
6  1 0  0 0 0 0  1 9  0 0 0  0 1 0 1 8
6  0 0  0 0 0 0  0 0  0 0 0  0 1 1 1 9
6  0 0  0 0 0 0  0 0  0 0 0  0 0 0 0 0

// ==== compile.f ====
hdl/SchedulerPkg.sv
hdl/WakeupSelectIf.sv
hdl/ReadyBitTable.sv
hdl/ProducerMatrix.sv
hdl/WakeupLogic.sv
hdl/EntryAllocator.sv
hdl/SelectLogic.sv
hdl/IssueScheduler.sv
dv/IssueSchedulerTb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= IssueSchedulerTb
FILELIST   ?= compile.f
OBJDIR     ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	grep -qx "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
